//--- cba_data_pkg.sv
// Number formats shared by the content addressing datapath
// Elements are signed two's complement, ELEM_W bits
// ACC_W covers 16 products of full scale elements without overflow
// Result word is read as a row pair or as the run summary
`default_nettype none

package cba_data_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Key and memory element
  localparam int ELEM_W = 8;

  // Dot and norm sums
  localparam int ACC_W = 20;

  // Row and element counters, also the best row index
  localparam int IDX_W = 8;

  // Full result word
  localparam int RES_W = 2 * ACC_W;

  ////////////////////
  // Result word
  ////////////////////

  // Row view carries both sums of one memory row
  // Summary view carries the argmax after the last row
  typedef union packed {
    struct packed {
      logic signed [ACC_W-1:0] dot;
      logic        [ACC_W-1:0] norm;
    } row;
    struct packed {
      // Always zero in a summary word
      logic [RES_W-IDX_W-2:0] pad;
      // Set when at least one row had a positive dot sum
      logic                   found;
      logic [IDX_W-1:0]       best_idx;
    } summary;
  } result_word_u;

endpackage

`default_nettype wire

//--- cba_ctrl_pkg.sv
// Control codes for the addressing run
// MAX_LEN and MAX_ROWS of the top level must stay within the limits here
`default_nettype none

package cba_ctrl_pkg;

  ////////////////////
  // Sequencer states
  ////////////////////

  localparam int STATE_W = 2;

  // Waiting for START, READY high
  localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
  // Loading the key vector
  localparam logic [STATE_W-1:0] ST_KEY  = 2'd1;
  // Streaming memory rows
  localparam logic [STATE_W-1:0] ST_ROWS = 2'd2;
  // Last row taken, summary pending
  localparam logic [STATE_W-1:0] ST_DONE = 2'd3;

  ////////////////////
  // Parameter limits
  ////////////////////

  // Longest key and row, bound by ACC_W headroom
  localparam int LEN_LIMIT = 16;

  // Most rows per run, bound by IDX_W
  localparam int ROW_LIMIT = 255;

endpackage

`default_nettype wire

//--- cba_row_sequencer.sv
// Run sequencer, key phase then row phase
// SIZE_I and SIZE_J are latched on START and must be at least 1
// Strobes arriving outside their phase are dropped
// run_last is registered so that it lines up with the unit sum strobes
`default_nettype none

module cba_row_sequencer #(
  parameter int MAX_LEN  = 16,
  parameter int MAX_ROWS = 255
) (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            START,
  input  wire [cba_data_pkg::IDX_W-1:0] SIZE_I,
  input  wire [cba_data_pkg::IDX_W-1:0] SIZE_J,
  input  wire                            K_IN_ENABLE,
  input  wire                            M_IN_ENABLE,
  output logic                           READY,
  output logic                           key_load,
  output logic                           elem_valid,
  output logic                           row_first,
  output logic                           row_last,
  output logic                           run_last
);

  logic [cba_ctrl_pkg::STATE_W-1:0] state;
  logic [cba_data_pkg::IDX_W-1:0]   size_i_q;
  logic [cba_data_pkg::IDX_W-1:0]   size_j_q;
  logic [cba_data_pkg::IDX_W-1:0]   elem_cnt;
  logic [cba_data_pkg::IDX_W-1:0]   row_cnt;
  logic [cba_data_pkg::IDX_W-1:0]   j_last;
  logic [cba_data_pkg::IDX_W-1:0]   i_last;

  ////////////////////
  // Strobe decode
  ////////////////////

  // Terminal counts
  assign j_last = size_j_q - 1'b1;
  assign i_last = size_i_q - 1'b1;

  // Accepted strobes pass straight through
  assign key_load   = (state == cba_ctrl_pkg::ST_KEY) && K_IN_ENABLE;
  assign elem_valid = (state == cba_ctrl_pkg::ST_ROWS) && M_IN_ENABLE;

  // Row markers from the element counter
  assign row_first = elem_valid && (elem_cnt == '0);
  assign row_last  = elem_valid && (elem_cnt == j_last);

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= cba_ctrl_pkg::ST_IDLE;
      READY    <= 1'b1;
      size_i_q <= '0;
      size_j_q <= '0;
      elem_cnt <= '0;
      row_cnt  <= '0;
      run_last <= 1'b0;
    end else begin
      // High for one cycle after the last element of the last row
      run_last <= row_last && (row_cnt == i_last);
      case (state)
        cba_ctrl_pkg::ST_IDLE: begin
          if (START) begin
            size_i_q <= SIZE_I;
            size_j_q <= SIZE_J;
            elem_cnt <= '0;
            row_cnt  <= '0;
            READY    <= 1'b0;
            state    <= cba_ctrl_pkg::ST_KEY;
          end
        end
        cba_ctrl_pkg::ST_KEY: begin
          if (key_load) begin
            if (elem_cnt == j_last) begin
              elem_cnt <= '0;
              state    <= cba_ctrl_pkg::ST_ROWS;
            end else begin
              elem_cnt <= elem_cnt + 1'b1;
            end
          end
        end
        cba_ctrl_pkg::ST_ROWS: begin
          if (row_last) begin
            elem_cnt <= '0;
            if (row_cnt == i_last) begin
              row_cnt <= '0;
              state   <= cba_ctrl_pkg::ST_DONE;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end else if (elem_valid) begin
            elem_cnt <= elem_cnt + 1'b1;
          end
        end
        cba_ctrl_pkg::ST_DONE: begin
          // Wait out the row word, READY rises with the summary word
          if (!run_last) begin
            READY <= 1'b1;
            state <= cba_ctrl_pkg::ST_IDLE;
          end
        end
        default: state <= cba_ctrl_pkg::ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Key and memory streams share no cycle
  assert property (@(posedge CLK) disable iff (RST) !(K_IN_ENABLE && M_IN_ENABLE));

  assert property (@(posedge CLK) disable iff (RST)
    (MAX_LEN <= cba_ctrl_pkg::LEN_LIMIT) && (MAX_ROWS <= cba_ctrl_pkg::ROW_LIMIT));

  // Latched sizes stay within what the key buffer and counters hold
  assert property (@(posedge CLK) disable iff (RST)
    (state != cba_ctrl_pkg::ST_IDLE) |-> (size_j_q <= MAX_LEN) && (size_i_q <= MAX_ROWS));

endmodule

`default_nettype wire

//--- cba_dot_unit.sv
// Key buffer and per-row dot product k . M[i]
// The key must be fully loaded before the first row element
// Write pointer rewinds once rows begin, so the next run reloads from 0
`default_nettype none

module cba_dot_unit #(
  parameter int MAX_LEN = 16
) (
  input  wire                                    CLK,
  input  wire                                    RST,
  input  wire                                    key_load,
  input  wire signed [cba_data_pkg::ELEM_W-1:0] K_IN,
  input  wire                                    elem_valid,
  input  wire                                    row_first,
  input  wire                                    row_last,
  input  wire signed [cba_data_pkg::ELEM_W-1:0] M_IN,
  output logic                                   dot_valid,
  output logic signed [cba_data_pkg::ACC_W-1:0] dot_sum
);

  localparam int PTR_W = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1;

  logic signed [cba_data_pkg::ELEM_W-1:0]   key_mem [MAX_LEN];
  logic        [PTR_W-1:0]                  wr_ptr;
  logic        [PTR_W-1:0]                  rd_ptr;
  logic        [PTR_W-1:0]                  rd_idx;
  logic signed [cba_data_pkg::ELEM_W-1:0]   key_rd;
  logic signed [2*cba_data_pkg::ELEM_W-1:0] prod;
  logic signed [cba_data_pkg::ACC_W-1:0]    acc;
  logic signed [cba_data_pkg::ACC_W-1:0]    acc_base;
  logic signed [cba_data_pkg::ACC_W-1:0]    acc_next;

  ////////////////////
  // Key buffer
  ////////////////////

  always_ff @(posedge CLK) begin
    if (key_load) begin
      key_mem[wr_ptr] <= K_IN;
    end
  end

  // First element of a row reads slot 0 in the same cycle
  assign rd_idx = row_first ? '0 : rd_ptr;
  assign key_rd = key_mem[rd_idx];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (key_load) begin
        wr_ptr <= wr_ptr + 1'b1;
      end else if (elem_valid) begin
        wr_ptr <= '0;
      end
      if (elem_valid) begin
        rd_ptr <= rd_idx + 1'b1;
      end
    end
  end

  ////////////////////
  // Accumulator
  ////////////////////

  // Signed product, sign extended into the sum
  assign prod     = key_rd * M_IN;
  assign acc_base = row_first ? '0 : acc;
  assign acc_next = acc_base + prod;

  always_ff @(posedge CLK) begin
    if (elem_valid) begin
      acc <= acc_next;
    end
    // Final sum includes the last element
    if (row_last) begin
      dot_sum <= acc_next;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      dot_valid <= 1'b0;
    end else begin
      dot_valid <= row_last;
    end
  end

endmodule

`default_nettype wire

//--- cba_norm_unit.sv
// Per-row squared norm M[i] . M[i]
// Sum is unsigned, at most 16 x 128^2 with the default widths
`default_nettype none

module cba_norm_unit (
  input  wire                                    CLK,
  input  wire                                    RST,
  input  wire                                    elem_valid,
  input  wire                                    row_first,
  input  wire                                    row_last,
  input  wire signed [cba_data_pkg::ELEM_W-1:0] M_IN,
  output logic                                   norm_valid,
  output logic        [cba_data_pkg::ACC_W-1:0] norm_sum
);

  logic signed [2*cba_data_pkg::ELEM_W-1:0] sq;
  logic        [cba_data_pkg::ACC_W-1:0]    acc;
  logic        [cba_data_pkg::ACC_W-1:0]    acc_base;
  logic        [cba_data_pkg::ACC_W-1:0]    acc_next;

  // Square never goes negative, so zero extension is safe
  assign sq       = M_IN * M_IN;
  assign acc_base = row_first ? '0 : acc;
  assign acc_next = acc_base + cba_data_pkg::ACC_W'($unsigned(sq));

  ////////////////////
  // Accumulator
  ////////////////////

  always_ff @(posedge CLK) begin
    if (elem_valid) begin
      acc <= acc_next;
    end
    if (row_last) begin
      norm_sum <= acc_next;
    end
  end

  // Strobe in step with the dot unit
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      norm_valid <= 1'b0;
    end else begin
      norm_valid <= row_last;
    end
  end

endmodule

`default_nettype wire

//--- cba_match_combiner.sv
// Row result output and hard argmax over cosine similarity
// Compares dot^2 * norm_best against dot_best^2 * norm, no divide or root
// Rows with a dot sum of zero or below never become the best row
// The key norm is the same for every row and is left out
`default_nettype none

module cba_match_combiner (
  input  wire                                    CLK,
  input  wire                                    RST,
  input  wire                                    dot_valid,
  input  wire signed [cba_data_pkg::ACC_W-1:0]  dot_sum,
  input  wire                                    norm_valid,
  input  wire        [cba_data_pkg::ACC_W-1:0]  norm_sum,
  input  wire                                    run_last,
  output logic                                   C_OUT_ENABLE,
  output cba_data_pkg::result_word_u             C_OUT,
  output logic                                   SUMMARY
);

  localparam int ACC_W = cba_data_pkg::ACC_W;

  logic [cba_ctrl_pkg::STATE_W-1:0] phase;
  logic [cba_data_pkg::IDX_W-1:0]   row_cnt;
  logic [cba_data_pkg::IDX_W-1:0]   best_idx;
  logic                             found;
  logic [ACC_W-1:0]                 best_dot;
  logic [ACC_W-1:0]                 best_norm;
  logic [ACC_W-1:0]                 dot_mag;
  logic [2*ACC_W-1:0]               dot_sq;
  logic [2*ACC_W-1:0]               best_sq;
  logic [3*ACC_W-1:0]               lhs;
  logic [3*ACC_W-1:0]               rhs;
  logic                             candidate;
  logic                             better;

  ////////////////////
  // Compare
  ////////////////////

  // Only positive similarity counts
  assign candidate = (dot_sum > 0) && (norm_sum != '0);
  assign dot_mag   = $unsigned(dot_sum);

  assign dot_sq  = dot_mag * dot_mag;
  assign best_sq = best_dot * best_dot;
  assign lhs     = dot_sq * best_norm;
  assign rhs     = best_sq * norm_sum;

  // Strict compare keeps the lower index on a tie
  assign better = candidate && (!found || (lhs > rhs));

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase        <= cba_ctrl_pkg::ST_IDLE;
      C_OUT_ENABLE <= 1'b0;
      SUMMARY      <= 1'b0;
      row_cnt      <= '0;
      best_idx     <= '0;
      found        <= 1'b0;
    end else begin
      C_OUT_ENABLE <= 1'b0;
      SUMMARY      <= 1'b0;
      if (phase == cba_ctrl_pkg::ST_DONE) begin
        // Summary goes out, then the run state is dropped
        C_OUT_ENABLE <= 1'b1;
        SUMMARY      <= 1'b1;
        phase        <= cba_ctrl_pkg::ST_IDLE;
        row_cnt      <= '0;
        best_idx     <= '0;
        found        <= 1'b0;
      end else if (dot_valid) begin
        C_OUT_ENABLE <= 1'b1;
        row_cnt      <= row_cnt + 1'b1;
        if (better) begin
          found    <= 1'b1;
          best_idx <= row_cnt;
        end
        if (run_last) begin
          phase <= cba_ctrl_pkg::ST_DONE;
        end
      end
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge CLK) begin
    if (dot_valid && better) begin
      best_dot  <= dot_mag;
      best_norm <= norm_sum;
    end
    if (phase == cba_ctrl_pkg::ST_DONE) begin
      C_OUT.summary.pad      <= '0;
      C_OUT.summary.found    <= found;
      C_OUT.summary.best_idx <= best_idx;
    end else if (dot_valid) begin
      C_OUT.row.dot  <= dot_sum;
      C_OUT.row.norm <= norm_sum;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Both units see the same row ends
  assert property (@(posedge CLK) disable iff (RST) dot_valid == norm_valid);

  // Run end from the sequencer lands on a row strobe
  assert property (@(posedge CLK) disable iff (RST) run_last |-> dot_valid);

endmodule

`default_nettype wire

//--- cba_content_addressing.sv
// Content based addressing top, fixed point, hard argmax only
// START also latches SIZE_I and SIZE_J, sizes must be at least 1
// No back-pressure, C_OUT words must be taken when C_OUT_ENABLE is high
// Parameters must stay within the limits of the control package
`default_nettype none

module cba_content_addressing #(
  parameter int MAX_LEN  = 16,
  parameter int MAX_ROWS = 255
) (
  input  wire                                    CLK,
  input  wire                                    RST,
  input  wire                                    START,
  input  wire        [cba_data_pkg::IDX_W-1:0]  SIZE_I,
  input  wire        [cba_data_pkg::IDX_W-1:0]  SIZE_J,
  input  wire                                    K_IN_ENABLE,
  input  wire signed [cba_data_pkg::ELEM_W-1:0] K_IN,
  input  wire                                    M_IN_ENABLE,
  input  wire signed [cba_data_pkg::ELEM_W-1:0] M_IN,
  output wire                                    READY,
  output wire                                    C_OUT_ENABLE,
  output cba_data_pkg::result_word_u             C_OUT,
  output wire                                    SUMMARY
);

  // Sequencer strobes
  wire key_load;
  wire elem_valid;
  wire row_first;
  wire row_last;
  wire run_last;

  // Row sums
  wire                                   dot_valid;
  wire signed [cba_data_pkg::ACC_W-1:0] dot_sum;
  wire                                   norm_valid;
  wire        [cba_data_pkg::ACC_W-1:0] norm_sum;

  ////////////////////
  // Sequencer
  ////////////////////

  cba_row_sequencer #(
    .MAX_LEN (MAX_LEN),
    .MAX_ROWS(MAX_ROWS)
  ) u_seq (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .SIZE_I     (SIZE_I),
    .SIZE_J     (SIZE_J),
    .K_IN_ENABLE(K_IN_ENABLE),
    .M_IN_ENABLE(M_IN_ENABLE),
    .READY      (READY),
    .key_load   (key_load),
    .elem_valid (elem_valid),
    .row_first  (row_first),
    .row_last   (row_last),
    .run_last   (run_last)
  );

  ////////////////////
  // Row datapath
  ////////////////////

  // Dot and norm run side by side on the same element
  cba_dot_unit #(
    .MAX_LEN(MAX_LEN)
  ) u_dot (
    .CLK       (CLK),
    .RST       (RST),
    .key_load  (key_load),
    .K_IN      (K_IN),
    .elem_valid(elem_valid),
    .row_first (row_first),
    .row_last  (row_last),
    .M_IN      (M_IN),
    .dot_valid (dot_valid),
    .dot_sum   (dot_sum)
  );

  cba_norm_unit u_norm (
    .CLK       (CLK),
    .RST       (RST),
    .elem_valid(elem_valid),
    .row_first (row_first),
    .row_last  (row_last),
    .M_IN      (M_IN),
    .norm_valid(norm_valid),
    .norm_sum  (norm_sum)
  );

  ////////////////////
  // Combiner
  ////////////////////

  cba_match_combiner u_cmb (
    .CLK         (CLK),
    .RST         (RST),
    .dot_valid   (dot_valid),
    .dot_sum     (dot_sum),
    .norm_valid  (norm_valid),
    .norm_sum    (norm_sum),
    .run_last    (run_last),
    .C_OUT_ENABLE(C_OUT_ENABLE),
    .C_OUT       (C_OUT),
    .SUMMARY     (SUMMARY)
  );

endmodule

`default_nettype wire

//--- cba_tb_ref.svh
// Reference model for the content addressing testbench
// Reads key_v and mem_v of the including module, sizes passed in
// Sums held in longint, wide enough for the cross products
`ifndef CBA_TB_REF_SVH
`define CBA_TB_REF_SVH

// k . M[row] over the first nj elements
function automatic longint row_dot(input int row, input int nj);
  longint s;
  s = 0;
  for (int j = 0; j < nj; j++) begin
    s += longint'(key_v[j]) * longint'(mem_v[row][j]);
  end
  return s;
endfunction

// M[row] . M[row]
function automatic longint row_norm(input int row, input int nj);
  longint s;
  s = 0;
  for (int j = 0; j < nj; j++) begin
    s += longint'(mem_v[row][j]) * longint'(mem_v[row][j]);
  end
  return s;
endfunction

// Highest cosine among rows with positive dot, lower index on a tie
function automatic void pick_best(input int ni, input int nj, output bit found, output int idx);
  longint d;
  longint n;
  longint bd;
  longint bn;
  found = 1'b0;
  idx = 0;
  bd = 0;
  bn = 0;
  for (int i = 0; i < ni; i++) begin
    d = row_dot(i, nj);
    n = row_norm(i, nj);
    // d^2 / n against bd^2 / bn, cross multiplied
    if ((d > 0) && (n != 0) && (!found || (d * d * bn > bd * bd * n))) begin
      found = 1'b1;
      idx = i;
      bd = d;
      bn = n;
    end
  end
endfunction

`endif

//--- cba_tb.sv
// Self-checking testbench for the content addressing top
// Inputs change 2 ns after the rising edge, outputs sampled on the falling edge
// Expected words come from the included reference, in arrival order
// Random rows use the full signed 8-bit range
`default_nettype none

module cba_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_LEN   = 16;
  localparam int MAX_ROWS  = 8;
  localparam int MAX_GAP   = 3;
  localparam int N_RAND    = 6;
  localparam int N_DIR     = 3;
  localparam int RES_W     = cba_data_pkg::RES_W;
  localparam int ACC_W     = cba_data_pkg::ACC_W;
  localparam int IDX_W     = cba_data_pkg::IDX_W;
  // Start, key and all rows of the largest run
  localparam int RUN_ELEMS = MAX_LEN * (MAX_ROWS + 1) + 1;
  localparam int LIMIT     = (2 * N_RAND + N_DIR) * RUN_ELEMS * (MAX_GAP + 1) + 400;

  logic                             CLK;
  logic                             RST;
  logic                             start;
  logic [IDX_W-1:0]                 size_i;
  logic [IDX_W-1:0]                 size_j;
  logic                             k_in_enable;
  logic signed [7:0]                k_in;
  logic                             m_in_enable;
  logic signed [7:0]                m_in;
  wire                              ready;
  wire                              c_out_enable;
  wire                              summary;
  cba_data_pkg::result_word_u       c_out;

  // Vectors of the current run
  int key_v [MAX_LEN];
  int mem_v [MAX_ROWS][MAX_LEN];

  logic [RES_W-1:0]           exp_q [$];
  bit                         exp_sum_q [$];
  logic [RES_W-1:0]           exp_w;
  bit                         exp_s;
  cba_data_pkg::result_word_u last_summary;
  int cyc = 0;
  int err_cnt = 0;
  int check_cnt = 0;
  int summ_cnt = 0;
  int last_row_cyc = 0;

  `include "cba_tb_ref.svh"

  cba_content_addressing #(
    .MAX_LEN (MAX_LEN),
    .MAX_ROWS(MAX_ROWS)
  ) dut (
    .CLK         (CLK),
    .RST         (RST),
    .START       (start),
    .SIZE_I      (size_i),
    .SIZE_J      (size_j),
    .K_IN_ENABLE (k_in_enable),
    .K_IN        (k_in),
    .M_IN_ENABLE (m_in_enable),
    .M_IN        (m_in),
    .READY       (ready),
    .C_OUT_ENABLE(c_out_enable),
    .C_OUT       (c_out),
    .SUMMARY     (summary)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  ////////////////////
  // Timeout
  ////////////////////

  always @(posedge CLK) begin
    cyc++;
    if (cyc >= LIMIT) begin
      $display("timeout: run still busy after %0d cycles", cyc);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////
  // Output checker
  ////////////////////

  always @(negedge CLK) begin
    if (!RST && c_out_enable) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("output word at %0t arrived with nothing expected", $time);
      end else begin
        exp_w = exp_q.pop_front();
        exp_s = exp_sum_q.pop_front();
        check_cnt++;
        assert (c_out == exp_w) else begin
          err_cnt++;
          $display("FAIL time=%0t signal=C_OUT expected=%h actual=%h", $time, exp_w, c_out);
        end
        assert (summary == exp_s) else begin
          err_cnt++;
          $display("FAIL time=%0t signal=SUMMARY expected=%b actual=%b", $time, exp_s, summary);
        end
        if (exp_s) begin
          // Summary sits right behind the last row word
          assert (cyc == last_row_cyc + 1) else begin
            err_cnt++;
            $display("summary word at %0t did not follow the last row word", $time);
          end
          assert (ready) else begin
            err_cnt++;
            $display("FAIL time=%0t signal=READY expected=1 actual=0", $time);
          end
          last_summary = c_out;
          summ_cnt++;
        end else begin
          last_row_cyc = cyc;
          assert (!ready) else begin
            err_cnt++;
            $display("FAIL time=%0t signal=READY expected=0 actual=1", $time);
          end
        end
      end
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic int rand_elem();
    return int'($urandom % 256) - 128;
  endfunction

  task automatic drive(input bit st, input bit ke, input int kv, input bit me, input int mv);
    @(posedge CLK);
    #2;
    start = st;
    k_in_enable = ke;
    k_in = kv[7:0];
    m_in_enable = me;
    m_in = mv[7:0];
  endtask

  // Idle cycles, with stray strobes of the other stream now and then
  task automatic idle_gap(input int max_gap, input bit in_key);
    int n;
    bit stray;
    n = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
    repeat (n) begin
      stray = ($urandom % 4) == 0;
      if (in_key) begin
        drive(1'b0, 1'b0, rand_elem(), stray, rand_elem());
      end else begin
        drive(1'b0, stray, rand_elem(), 1'b0, rand_elem());
      end
    end
  endtask

  task automatic run_case(input int ni, input int nj, input int max_gap);
    longint d;
    longint n;
    bit found;
    int best;
    int summ_before;
    summ_before = summ_cnt;
    for (int i = 0; i < ni; i++) begin
      d = row_dot(i, nj);
      n = row_norm(i, nj);
      exp_q.push_back({d[ACC_W-1:0], n[ACC_W-1:0]});
      exp_sum_q.push_back(1'b0);
    end
    pick_best(ni, nj, found, best);
    exp_q.push_back({{(RES_W - IDX_W - 1){1'b0}}, found, best[IDX_W-1:0]});
    exp_sum_q.push_back(1'b1);
    while (!ready) begin
      drive(1'b0, 1'b0, 0, 1'b0, 0);
    end
    drive(1'b1, 1'b0, 0, 1'b0, 0);
    size_i = ni[IDX_W-1:0];
    size_j = nj[IDX_W-1:0];
    drive(1'b0, 1'b0, 0, 1'b0, 0);
    assert (!ready) else begin
      err_cnt++;
      $display("FAIL time=%0t signal=READY expected=0 actual=1", $time);
    end
    for (int j = 0; j < nj; j++) begin
      idle_gap(max_gap, 1'b1);
      drive(1'b0, 1'b1, key_v[j], 1'b0, 0);
    end
    for (int i = 0; i < ni; i++) begin
      for (int j = 0; j < nj; j++) begin
        idle_gap(max_gap, 1'b0);
        drive(1'b0, 1'b0, 0, 1'b1, mem_v[i][j]);
      end
    end
    drive(1'b0, 1'b0, 0, 1'b0, 0);
    while (summ_cnt == summ_before) begin
      @(posedge CLK);
    end
  endtask

  task automatic fill_random(input int ni, input int nj);
    for (int j = 0; j < nj; j++) begin
      key_v[j] = rand_elem();
    end
    for (int i = 0; i < ni; i++) begin
      for (int j = 0; j < nj; j++) begin
        mem_v[i][j] = rand_elem();
      end
    end
  endtask

  // Four element rows for the directed cases
  task automatic set_row(input int r, input int a, input int b, input int c, input int d);
    mem_v[r][0] = a;
    mem_v[r][1] = b;
    mem_v[r][2] = c;
    mem_v[r][3] = d;
  endtask

  task automatic check_best(input bit exp_found, input int exp_idx);
    check_cnt++;
    assert (last_summary.summary.found == exp_found) else begin
      err_cnt++;
      $display("FAIL time=%0t signal=C_OUT.summary.found expected=%b actual=%b",
               $time, exp_found, last_summary.summary.found);
    end
    if (exp_found) begin
      assert (last_summary.summary.best_idx == exp_idx) else begin
        err_cnt++;
        $display("FAIL time=%0t signal=C_OUT.summary.best_idx expected=%0d actual=%0d",
                 $time, exp_idx, last_summary.summary.best_idx);
      end
    end
  endtask

  task automatic case_done(input string name, input int err_before);
    $display("case %-22s errors %0d", name, err_cnt - err_before);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int seed_val;
    int e0;
    int ni;
    int nj;
    seed_val = $urandom(32'hfc748ee3);
    RST = 1'b1;
    start = 1'b0;
    size_i = '0;
    size_j = '0;
    k_in_enable = 1'b0;
    k_in = '0;
    m_in_enable = 1'b0;
    m_in = '0;
    e0 = err_cnt;
    repeat (2) @(posedge CLK);
    #2;
    RST = 1'b0;
    assert (ready) else begin
      err_cnt++;
      $display("FAIL time=%0t signal=READY expected=1 actual=%b", $time, ready);
    end
    assert (!c_out_enable) else begin
      err_cnt++;
      $display("FAIL time=%0t signal=C_OUT_ENABLE expected=0 actual=%b",
               $time, c_out_enable);
    end
    case_done("reset", e0);

    // Same data without and with gaps, sizes change run to run
    for (int r = 0; r < N_RAND; r++) begin
      ni = 1 + int'($urandom % MAX_ROWS);
      nj = 1 + int'($urandom % MAX_LEN);
      fill_random(ni, nj);
      e0 = err_cnt;
      run_case(ni, nj, 0);
      case_done($sformatf("random %0dx%0d", ni, nj), e0);
      e0 = err_cnt;
      run_case(ni, nj, MAX_GAP);
      case_done($sformatf("random gapped %0dx%0d", ni, nj), e0);
    end

    // Scaled key copy beats a longer row
    key_v[0] = 5;
    key_v[1] = -3;
    key_v[2] = 7;
    key_v[3] = 2;
    set_row(0, 40, 10, 60, 30);
    set_row(1, 15, -9, 21, 6);
    e0 = err_cnt;
    run_case(2, 4, 1);
    check_best(1'b1, 1);
    case_done("scaled copy", e0);

    // Rows 1 and 2 both parallel to the key
    set_row(0, 5, 3, 7, 2);
    set_row(1, 5, -3, 7, 2);
    set_row(2, 10, -6, 14, 4);
    e0 = err_cnt;
    run_case(3, 4, 2);
    check_best(1'b1, 1);
    case_done("tie", e0);

    // Negative, zero and orthogonal rows
    set_row(0, -5, 3, -7, -2);
    set_row(1, 0, 0, 0, 0);
    set_row(2, 3, 5, 0, 0);
    e0 = err_cnt;
    run_case(3, 4, 0);
    check_best(1'b0, 0);
    case_done("no positive dot", e0);

    assert (exp_q.size() == 0) else begin
      err_cnt++;
      $display("%0d expected words never arrived", exp_q.size());
    end
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
cba_data_pkg.sv
cba_ctrl_pkg.sv
cba_row_sequencer.sv
cba_dot_unit.sv
cba_norm_unit.sv
cba_match_combiner.sv
cba_content_addressing.sv
cba_tb.sv

//--- Bender.yml
package:
  name: cba_content_addressing

sources:
  - files:
      - cba_data_pkg.sv
      - cba_ctrl_pkg.sv
      - cba_row_sequencer.sv
      - cba_dot_unit.sv
      - cba_norm_unit.sv
      - cba_match_combiner.sv
      - cba_content_addressing.sv
  - target: test
    include_dirs:
      - .
    files:
      - cba_tb.sv
